// File: logic/bramArrayPkg.sv
// Shared geometry constants and word types for the BRAM array, imported by the RTL and testbench
`default_nettype none

package bramArrayPkg;

  // One RAM cell is 32 bits wide and 1024 words deep
  localparam int BramBitWidth     = 32;
  localparam int BramByteWidth    = BramBitWidth / 8;  // Byte lanes per cell
  localparam int BramWordIdxWidth = 10;                // Word index inside one cell

  // Port addressing
  localparam int ByteAddrWidth = 16;
  localparam int WordAddrWidth = 14;  // Byte address bits 15 down to 2
  localparam int SerIdxWidth   = WordAddrWidth - BramWordIdxWidth;

  // One cell word and its byte enables
  typedef logic [BramBitWidth-1:0]  bramWordT;
  typedef logic [BramByteWidth-1:0] bramByteEnT;

  // Word address split into row and word inside the row
  typedef struct packed {
    logic [SerIdxWidth-1:0]      serIdx;   // Row of cells
    logic [BramWordIdxWidth-1:0] wordIdx;  // Word inside each cell of the row
  } bramLocT;

  // Same word address, seen flat or as row and word index
  typedef union packed {
    logic [WordAddrWidth-1:0] wordAddr;
    bramLocT                  loc;
  } bramAddrT;

endpackage

`default_nettype wire

// File: logic/tdpBramCell.sv
// Behavioral true dual-port RAM cell, 32 bits by 1024 words, byte enables and write-first reads
`timescale 1ns/1ns
`default_nettype none

module tdpBramCell
  import bramArrayPkg::*;
(
  input  wire logic                        A_PS,
  input  wire logic                        rstN,

  // Port A
  input  wire logic                        aEn,
  input  wire bramByteEnT                  aWrEn,
  input  wire logic [BramWordIdxWidth-1:0] aWordIdx,
  input  wire bramWordT                    aWrData,
  output bramWordT                         aRdData,

  // Port B
  input  wire logic                        bEn,
  input  wire bramByteEnT                  bWrEn,
  input  wire logic [BramWordIdxWidth-1:0] bWordIdx,
  input  wire bramWordT                    bWrData,
  output bramWordT                         bRdData
);

  localparam int NumWords = 1 << BramWordIdxWidth;

  bramWordT mem [NumWords];

  bramWordT aMerged;  // Word as it stands after port A's write
  bramWordT bMerged;

  // Overlay the enabled bytes of a new word onto the stored one
  function automatic bramWordT mergeBytes(input bramWordT oldWord, input bramWordT newWord,
                                          input bramByteEnT byteEn);
    bramWordT merged;
    merged = oldWord;
    for (int i = 0; i < BramByteWidth; i++) begin
      if (byteEn[i]) begin
        merged[8*i +: 8] = newWord[8*i +: 8];
      end
    end
    return merged;
  endfunction

  // With no byte enabled this is the plain read value
  assign aMerged = mergeBytes(mem[aWordIdx], aWrData, aWrEn);
  assign bMerged = mergeBytes(mem[bWordIdx], bWrData, bWrEn);

  // Storage, both ports write through the merged word
  always_ff @(posedge A_PS) begin
    if (aEn && |aWrEn) begin
      mem[aWordIdx] <= aMerged;
    end
    if (bEn && |bWrEn) begin
      mem[bWordIdx] <= bMerged;
    end
  end

  // Read registers hold their value while the port is idle
  always_ff @(posedge A_PS) begin
    if (!rstN) begin
      aRdData <= '0;
      bRdData <= '0;
    end else begin
      if (aEn) begin
        aRdData <= aMerged;  // Write-first
      end
      if (bEn) begin
        bRdData <= bMerged;
      end
    end
  end

  // Same-word writes from both ports in one cycle leave the word undefined
  writeCollision: assert property (@(posedge A_PS) disable iff (!rstN)
    (aEn && bEn && |aWrEn && |bWrEn) |-> (aWordIdx != bWordIdx))
    else $error("Both ports write word %0d in the same cycle", aWordIdx);

endmodule

`default_nettype wire

// File: logic/bramPortSelect.sv
// Per-port address decode, row write-enable steering and registered read mux for the BRAM array
`timescale 1ns/1ns
`default_nettype none

module bramPortSelect
  import bramArrayPkg::*;
#(
  parameter int NumParBrams = 3,
  parameter int NumSerBrams = 8
) (
  input  wire logic                                          A_PS,
  input  wire logic                                          rstN,

  // Port side
  input  wire logic                                          en,
  input  wire logic [NumParBrams*BramByteWidth-1:0]          wrEn,
  input  wire logic [ByteAddrWidth-1:0]                      addr,

  // Cell side, one byte-enable vector per row
  output logic [NumSerBrams-1:0][NumParBrams*BramByteWidth-1:0] rowWrEn,
  output logic [BramWordIdxWidth-1:0]                        wordIdx,
  input  wire logic [NumSerBrams-1:0][NumParBrams*BramBitWidth-1:0] rowRdData,

  output logic [NumParBrams*BramBitWidth-1:0]                rdData
);

  localparam int LaneBytes = NumParBrams * BramByteWidth;
  localparam int DataWidth = NumParBrams * BramBitWidth;

  bramAddrT               addrView;
  logic [SerIdxWidth-1:0] rowIdx;
  logic [SerIdxWidth-1:0] rdRowIdx;  // Row of the access now in the cell read registers

  // Drop the byte offset, then read the word address as row plus word
  assign addrView.wordAddr = addr[ByteAddrWidth-1 -: WordAddrWidth];
  assign rowIdx            = addrView.loc.serIdx;
  assign wordIdx           = addrView.loc.wordIdx;  // Shared by every row

  // Only the addressed row sees the byte enables
  always_comb begin
    for (int s = 0; s < NumSerBrams; s++) begin
      if (en && (rowIdx == SerIdxWidth'(s))) begin
        rowWrEn[s] = wrEn;
      end else begin
        rowWrEn[s] = {LaneBytes{1'b0}};
      end
    end
  end

  // Row index follows the access into the cells' read register stage
  always_ff @(posedge A_PS) begin
    if (!rstN) begin
      rdRowIdx <= '0;
    end else if (en) begin
      rdRowIdx <= rowIdx;
    end
  end

  // Selecting by the registered row keeps back-to-back row changes aligned
  always_comb begin
    rdData = {DataWidth{1'b0}};
    for (int s = 0; s < NumSerBrams; s++) begin
      if (rdRowIdx == SerIdxWidth'(s)) begin
        rdData = rowRdData[s];
      end
    end
  end

  // Address must land inside the built rows
  rowInRange: assert property (@(posedge A_PS) disable iff (!rstN)
    en |-> (rowIdx < NumSerBrams))
    else $error("Row index %0d beyond %0d rows", rowIdx, NumSerBrams);

  // Byte enables only accompany an enabled access
  wrEnNeedsEn: assert property (@(posedge A_PS) disable iff (!rstN)
    !en |-> (wrEn == '0))
    else $error("Write enables set while port is disabled");

endmodule

`default_nettype wire

// File: logic/tdpBramArray.sv
// Top level of the dual-port BRAM array, a grid of RAM cells served by two port selectors
`timescale 1ns/1ns
`default_nettype none

module tdpBramArray
  import bramArrayPkg::*;
#(
  parameter int NumParBrams = 3,  // Cells side by side, widens the word
  parameter int NumSerBrams = 8   // Rows of cells, deepens the address space
) (
  input  wire logic                                 A_PS,
  input  wire logic                                 rstN,

  // Port A
  input  wire logic                                 aEn,
  input  wire logic [NumParBrams*BramByteWidth-1:0] aWrEn,
  input  wire logic [ByteAddrWidth-1:0]             aAddr,   // Byte address
  input  wire logic [NumParBrams*BramBitWidth-1:0]  aWrData,
  output logic [NumParBrams*BramBitWidth-1:0]       aRdData,

  // Port B
  input  wire logic                                 bEn,
  input  wire logic [NumParBrams*BramByteWidth-1:0] bWrEn,
  input  wire logic [ByteAddrWidth-1:0]             bAddr,
  input  wire logic [NumParBrams*BramBitWidth-1:0]  bWrData,
  output logic [NumParBrams*BramBitWidth-1:0]       bRdData
);

  localparam int LaneBytes = NumParBrams * BramByteWidth;
  localparam int DataWidth = NumParBrams * BramBitWidth;

  // Row index is only SerIdxWidth bits wide
  if (NumSerBrams > (1 << SerIdxWidth)) begin : gDepthCheck
    $error("NumSerBrams %0d exceeds the row index range", NumSerBrams);
  end

  logic [NumSerBrams-1:0][LaneBytes-1:0] aRowWrEn, bRowWrEn;
  logic [NumSerBrams-1:0][DataWidth-1:0] aRowRdData, bRowRdData;
  logic [BramWordIdxWidth-1:0]           aWordIdx, bWordIdx;

  bramPortSelect #(.NumParBrams(NumParBrams), .NumSerBrams(NumSerBrams)) uPortA (
    .A_PS, .rstN,
    .en(aEn), .wrEn(aWrEn), .addr(aAddr),
    .rowWrEn(aRowWrEn), .wordIdx(aWordIdx), .rowRdData(aRowRdData),
    .rdData(aRdData)
  );

  bramPortSelect #(.NumParBrams(NumParBrams), .NumSerBrams(NumSerBrams)) uPortB (
    .A_PS, .rstN,
    .en(bEn), .wrEn(bWrEn), .addr(bAddr),
    .rowWrEn(bRowWrEn), .wordIdx(bWordIdx), .rowRdData(bRowRdData),
    .rdData(bRdData)
  );

  // Cell grid, row s and lane p
  for (genvar s = 0; s < NumSerBrams; s++) begin : gRow
    for (genvar p = 0; p < NumParBrams; p++) begin : gLane
      tdpBramCell uCell (
        .A_PS, .rstN,
        .aEn(aEn),                                  // Every row reads, the mux picks one
        .aWrEn(aRowWrEn[s][p*BramByteWidth +: BramByteWidth]),
        .aWordIdx(aWordIdx),
        .aWrData(aWrData[p*BramBitWidth +: BramBitWidth]),
        .aRdData(aRowRdData[s][p*BramBitWidth +: BramBitWidth]),
        .bEn(bEn),
        .bWrEn(bRowWrEn[s][p*BramByteWidth +: BramByteWidth]),
        .bWordIdx(bWordIdx),
        .bWrData(bWrData[p*BramBitWidth +: BramBitWidth]),
        .bRdData(bRowRdData[s][p*BramBitWidth +: BramBitWidth])
      );
    end
  end

endmodule

`default_nettype wire

// File: bench/tbClockGen.sv
// Testbench clock and reset source, free-running clock with reset held low for the first edges
`timescale 1ns/1ns
`default_nettype none

module tbClockGen #(
  parameter int HalfPeriod  = 20,  // 40 ns clock period
  parameter int ResetCycles = 2,
  parameter int ReleaseSkew = 5    // Same skew as the stimulus
) (
  output logic A_PS,
  output logic rstN
);

  initial begin
    A_PS = 1'b0;
    forever #HalfPeriod A_PS = ~A_PS;
  end

  initial begin
    rstN = 1'b0;
    repeat (ResetCycles) @(posedge A_PS);
    #ReleaseSkew rstN = 1'b1;
  end

endmodule

`default_nettype wire

// File: bench/tdpBramArrayTb.sv
// Testbench top for the dual-port BRAM array that replays the access vector file and checks read data
`timescale 1ns/1ns
`default_nettype none

module tdpBramArrayTb
  import bramArrayPkg::*;
();

  localparam int    NumParBrams   = 3;
  localparam int    NumSerBrams   = 8;
  localparam int    LaneBytes     = NumParBrams * BramByteWidth;
  localparam int    DataWidth     = NumParBrams * BramBitWidth;
  localparam int    MaxRecords    = 64;
  localparam int    PadRecords    = 4;  // Idle cycles after the file's records
  localparam int    ResetCycles   = 2;
  localparam int    TimeoutMargin = 20;
  localparam int    DriveSkew     = 5;
  localparam int    SettleDelay   = 5;  // From the next drive to the read data check
  localparam string VectorFile    = "bench/bramAccessInput.txt";

  logic                     A_PS;
  logic                     rstN;
  logic                     aEn, bEn;
  logic [LaneBytes-1:0]     aWrEn, bWrEn;
  logic [ByteAddrWidth-1:0] aAddr, bAddr;
  logic [DataWidth-1:0]     aWrData, bWrData;
  logic [DataWidth-1:0]     aRdData, bRdData;

  // Records indexed by port with 0 for A and 1 for B
  logic                     recEn     [2][MaxRecords];
  logic [LaneBytes-1:0]     recWrEn   [2][MaxRecords];
  logic [ByteAddrWidth-1:0] recAddr   [2][MaxRecords];
  logic [DataWidth-1:0]     recWrData [2][MaxRecords];
  logic [DataWidth-1:0]     recExp    [2][MaxRecords];  // Read data one cycle after the access
  logic                     recChk    [2][MaxRecords];

  int numRecords = 0;
  int seed       = 32'h08544e5a;
  int cycleCount = 0;
  int cycleLimit = ResetCycles + MaxRecords + TimeoutMargin;  // Tightened once the file is read

  tbClockGen #(.HalfPeriod(20), .ResetCycles(ResetCycles), .ReleaseSkew(DriveSkew)) uClock (
    .A_PS(A_PS),
    .rstN(rstN)
  );

  tdpBramArray #(.NumParBrams(NumParBrams), .NumSerBrams(NumSerBrams)) UUT (
    .A_PS(A_PS), .rstN(rstN),
    .aEn(aEn), .aWrEn(aWrEn), .aAddr(aAddr), .aWrData(aWrData), .aRdData(aRdData),
    .bEn(bEn), .bWrEn(bWrEn), .bAddr(bAddr), .bWrData(bWrData), .bRdData(bRdData)
  );

  task automatic failRun(input string reason);
    $display("%s", reason);
    $display("STATUS: FAIL");
    $fatal(1, "Run aborted");
  endtask

  task automatic checkWord(input bramWordT actual, input bramWordT expected, input int lane,
                           input string port);
    if (actual !== expected) begin
      $display("** Error at %0t ns: port %s lane %0d read %h, expected %h",
               $time, port, lane, actual, expected);
      failRun("Read data differs from the expected value");
    end
  endtask

  task automatic checkRecord(input int k);
    for (int lane = 0; lane < NumParBrams; lane++) begin
      if (recChk[0][k]) begin
        checkWord(aRdData[lane*BramBitWidth +: BramBitWidth],
                  recExp[0][k][lane*BramBitWidth +: BramBitWidth], lane,
                  $sformatf("A, record %0d", k));
      end
      if (recChk[1][k]) begin
        checkWord(bRdData[lane*BramBitWidth +: BramBitWidth],
                  recExp[1][k][lane*BramBitWidth +: BramBitWidth], lane,
                  $sformatf("B, record %0d", k));
      end
    end
  endtask

  // Each record is an A line followed by a B line
  task automatic loadVectors();
    int                       fd;
    int                       fields;
    int                       port;
    bit                       wantB;
    string                    line;
    logic                     en;
    logic [LaneBytes-1:0]     wrEn;
    logic [ByteAddrWidth-1:0] addr;
    logic [DataWidth-1:0]     wrData;
    logic [DataWidth-1:0]     expRd;
    logic                     chk;
    fd = $fopen(VectorFile, "r");
    if (fd == 0) begin
      failRun($sformatf("Cannot open the vector file %s", VectorFile));
    end
    wantB = 1'b0;
    while ($fgets(line, fd) > 0) begin
      if (line.len() < 2 || line[0] == "#") begin
        continue;  // Blank or comment line
      end
      if ((wantB && line[0] != "B") || (!wantB && line[0] != "A")) begin
        failRun($sformatf("Vector line out of order: %s", line));
      end
      if (numRecords >= MaxRecords - PadRecords) begin
        failRun("Vector file holds more records than the testbench can store");
      end
      port   = wantB ? 1 : 0;
      fields = $sscanf(line.substr(1, line.len() - 1), "%h %h %h %h %h %h",
                       en, wrEn, addr, wrData, expRd, chk);
      if (fields != 6) begin
        failRun($sformatf("Malformed vector line: %s", line));
      end
      recEn[port][numRecords]     = en;
      recWrEn[port][numRecords]   = wrEn;
      recAddr[port][numRecords]   = addr;
      recWrData[port][numRecords] = wrData;
      recExp[port][numRecords]    = expRd;
      recChk[port][numRecords]    = chk;
      if (wantB) begin
        numRecords++;
      end
      wantB = !wantB;
    end
    $fclose(fd);
    if (wantB) begin
      failRun("Vector file ends with an A line that has no B line");
    end
    if (numRecords == 0) begin
      failRun("Vector file holds no records");
    end
  endtask

  // Idle cycles with moving address and data while read data holds
  task automatic addPadding();
    int prev;
    for (int i = 0; i < PadRecords; i++) begin
      prev = numRecords - 1;
      for (int p = 0; p < 2; p++) begin
        recEn[p][numRecords]     = 1'b0;
        recWrEn[p][numRecords]   = '0;
        recAddr[p][numRecords]   = ByteAddrWidth'($random(seed));
        recWrData[p][numRecords] = {$random(seed), $random(seed), $random(seed)};
        recExp[p][numRecords]    = recExp[p][prev];
        recChk[p][numRecords]    = recChk[p][prev];
      end
      numRecords++;
    end
  endtask

  task automatic driveRecord(input int k);
    aEn     = recEn[0][k];
    aWrEn   = recWrEn[0][k];
    aAddr   = recAddr[0][k];
    aWrData = recWrData[0][k];
    bEn     = recEn[1][k];
    bWrEn   = recWrEn[1][k];
    bAddr   = recAddr[1][k];
    bWrData = recWrData[1][k];
  endtask

  // Run limit from the number of records
  always @(posedge A_PS) begin
    cycleCount <= cycleCount + 1;
    if (cycleCount >= cycleLimit) begin
      failRun($sformatf("Timeout, run did not end within %0d clock cycles", cycleLimit));
    end
  end

  initial begin
    aEn     = 1'b0;
    aWrEn   = '0;
    aAddr   = '0;
    aWrData = '0;
    bEn     = 1'b0;
    bWrEn   = '0;
    bAddr   = '0;
    bWrData = '0;
    loadVectors();
    addPadding();
    cycleLimit = ResetCycles + numRecords + TimeoutMargin;
    $display("Replaying %0d access records", numRecords);
    wait (rstN === 1'b1);
    driveRecord(0);
    for (int k = 0; k < numRecords; k++) begin
      @(posedge A_PS);
      #DriveSkew;
      if (k + 1 < numRecords) begin
        driveRecord(k + 1);  // Next access on the inputs, the read mux must not follow it
      end
      #SettleDelay;
      checkRecord(k);  // Access k was sampled at the last edge
    end
    $display("STATUS: PASS");
    $finish;
  end

endmodule

`default_nettype wire

// File: bench/bramAccessInput.txt
# Columns: port, en, byte enables, byte address, write data, expected read data, check flag
# One record per clock cycle as an A line then a B line, read data is checked a cycle later
# Reset values with both ports idle
A 0 000 0000 000000000000000000000000 000000000000000000000000 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
A 0 000 0000 000000000000000000000000 000000000000000000000000 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
# Full writes on port A in rows 0, 3 and 7, then read back
A 1 fff 0010 a0a0a001b0b0b001c0c0c001 a0a0a001b0b0b001c0c0c001 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
A 1 fff 3010 a3a3a304b3b3b304c3c3c304 a3a3a304b3b3b304c3c3c304 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
A 1 fff 7010 a7a7a708b7b7b708c7c7c708 a7a7a708b7b7b708c7c7c708 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
A 1 000 0010 000000000000000000000000 a0a0a001b0b0b001c0c0c001 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
A 1 000 3010 000000000000000000000000 a3a3a304b3b3b304c3c3c304 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
A 1 000 7010 000000000000000000000000 a7a7a708b7b7b708c7c7c708 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
# Same word index, back-to-back reads alternating rows
A 1 000 3010 000000000000000000000000 a3a3a304b3b3b304c3c3c304 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
A 1 000 0010 000000000000000000000000 a0a0a001b0b0b001c0c0c001 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
A 1 000 3010 000000000000000000000000 a3a3a304b3b3b304c3c3c304 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
# Partial byte enables merge with the old bytes, the write cycle returns the merged word
A 1 5a3 0010 112233445566778899aabbcc a022a04455b07701c0c0bbcc 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
A 1 000 0010 000000000000000000000000 a022a04455b07701c0c0bbcc 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
A 1 100 3010 ffffffeeffffffffffffffff a3a3a3eeb3b3b304c3c3c304 1
B 0 000 0000 000000000000000000000000 000000000000000000000000 1
A 1 000 3010 000000000000000000000000 a3a3a3eeb3b3b304c3c3c304 1
B 1 000 7010 000000000000000000000000 a7a7a708b7b7b708c7c7c708 1
# Words cross between the ports, reads of different rows in the same cycle
A 0 000 0000 000000000000000000000000 a3a3a3eeb3b3b304c3c3c304 1
B 1 fff 5020 a5a5a510b5b5b510c5c5c510 a5a5a510b5b5b510c5c5c510 1
A 1 000 5020 000000000000000000000000 a5a5a510b5b5b510c5c5c510 1
B 0 000 0000 000000000000000000000000 a5a5a510b5b5b510c5c5c510 1
A 1 fff 2040 a2a2a220b2b2b220c2c2c220 a2a2a220b2b2b220c2c2c220 1
B 1 000 3010 000000000000000000000000 a3a3a3eeb3b3b304c3c3c304 1
A 1 000 5020 000000000000000000000000 a5a5a510b5b5b510c5c5c510 1
B 1 000 2040 000000000000000000000000 a2a2a220b2b2b220c2c2c220 1
A 1 000 0010 000000000000000000000000 a022a04455b07701c0c0bbcc 1
B 1 0f0 2040 00000000deadbeef00000000 a2a2a220deadbeefc2c2c220 1
A 1 000 2040 000000000000000000000000 a2a2a220deadbeefc2c2c220 1
B 1 000 0010 000000000000000000000000 a022a04455b07701c0c0bbcc 1
A 1 000 7010 000000000000000000000000 a7a7a708b7b7b708c7c7c708 1
B 1 000 7010 000000000000000000000000 a7a7a708b7b7b708c7c7c708 1
# Port B fills rows 1 and 6, then both ports alternate rows
A 0 000 0000 000000000000000000000000 a7a7a708b7b7b708c7c7c708 1
B 1 fff 1010 a1a1a102b1b1b102c1c1c102 a1a1a102b1b1b102c1c1c102 1
A 0 000 0000 000000000000000000000000 a7a7a708b7b7b708c7c7c708 1
B 1 fff 6010 a6a6a606b6b6b606c6c6c606 a6a6a606b6b6b606c6c6c606 1
A 1 000 1010 000000000000000000000000 a1a1a102b1b1b102c1c1c102 1
B 1 000 6010 000000000000000000000000 a6a6a606b6b6b606c6c6c606 1
A 1 000 6010 000000000000000000000000 a6a6a606b6b6b606c6c6c606 1
B 1 000 1010 000000000000000000000000 a1a1a102b1b1b102c1c1c102 1
A 1 000 0010 000000000000000000000000 a022a04455b07701c0c0bbcc 1
B 1 000 7010 000000000000000000000000 a7a7a708b7b7b708c7c7c708 1
A 1 000 1010 000000000000000000000000 a1a1a102b1b1b102c1c1c102 1
B 1 000 3010 000000000000000000000000 a3a3a3eeb3b3b304c3c3c304 1
# Idle ports hold their read data while address and write data move
A 0 000 6010 0123456789abcdef01234567 a1a1a102b1b1b102c1c1c102 1
B 0 000 0010 555555555555555555555555 a3a3a3eeb3b3b304c3c3c304 1
A 0 000 2040 fedcba9876543210fedcba98 a1a1a102b1b1b102c1c1c102 1
B 0 000 5020 aaaaaaaaaaaaaaaaaaaaaaaa a3a3a3eeb3b3b304c3c3c304 1
A 1 000 5020 000000000000000000000000 a5a5a510b5b5b510c5c5c510 1
B 0 000 7010 0f0f0f0f0f0f0f0f0f0f0f0f a3a3a3eeb3b3b304c3c3c304 1
# Both ports write different words of row 4 in one cycle
A 1 fff 4000 a4a4a400b4b4b400c4c4c400 a4a4a400b4b4b400c4c4c400 1
B 1 fff 4004 d4d4d401e4e4e401f4f4f401 d4d4d401e4e4e401f4f4f401 1
A 1 000 4004 000000000000000000000000 d4d4d401e4e4e401f4f4f401 1
B 1 000 4000 000000000000000000000000 a4a4a400b4b4b400c4c4c400 1
A 0 000 1234 000000000000000000000000 d4d4d401e4e4e401f4f4f401 1
B 0 000 4321 000000000000000000000000 a4a4a400b4b4b400c4c4c400 1

// File: filelist.f
logic/bramArrayPkg.sv
logic/tdpBramCell.sv
logic/bramPortSelect.sv
logic/tdpBramArray.sv
bench/tbClockGen.sv
bench/tdpBramArrayTb.sv

// File: runSim.sh
#!/usr/bin/env bash
# Builds the BRAM array testbench with Verilator, runs it and checks the log for the pass message
set -u

cd "$(dirname "$0")" || exit 1

BUILD_DIR=obj_dir
SIM_EXE=simTdpBramArray
LOG_FILE=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module tdpBramArrayTb \
  -f filelist.f \
  --Mdir "$BUILD_DIR" -o "$SIM_EXE"
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

"./$BUILD_DIR/$SIM_EXE" > "$LOG_FILE" 2>&1
runStatus=$?
cat "$LOG_FILE"
if [ $runStatus -ne 0 ]; then
  echo "Simulation exited with status $runStatus"
  exit 1
fi

if grep -q "^STATUS: PASS$" "$LOG_FILE"; then
  exit 0
fi
echo "Pass message not found in $LOG_FILE"
exit 1
